// ==== logic/mxv_macros.svh ====
//------------------------------------------------
// Fixed sizing of the matrix-vector multiplier
// MXV_N and MXV_M must both be above 1
// Sums wrap at MXV_ACC_W bits, nothing saturates
//------------------------------------------------
`ifndef MXV_MACROS_SVH
`define MXV_MACROS_SVH

// Signed width of x and A elements
`define MXV_ELEM_W 16
// Accumulator and result width
`define MXV_ACC_W 40
// Vector length, entries held by the repeat buffer
`define MXV_N 4
// Rows of A, replays of each stored vector
`define MXV_M 3

`endif

// ==== logic/mxv_pkg.sv ====
//------------------------------------------------
// Data types shared by the multiplier blocks
// Widths come from the macros header
//------------------------------------------------
`include "mxv_macros.svh"

package mxv_pkg;

  // One vector or matrix element
  typedef logic signed [`MXV_ELEM_W-1:0] elem_t;

  // Running sum and row result
  typedef logic signed [`MXV_ACC_W-1:0] acc_t;

endpackage

// ==== logic/stream_if.sv ====
//------------------------------------------------
// Matrix element stream with a row-end flag
// Source holds data and last while stalled
//------------------------------------------------
`timescale 1ns/1ps

interface stream_if
  import mxv_pkg::*;
();

  elem_t data;
  logic  valid;
  logic  ready;
  // Marks the final element of a row
  logic  last;

  modport src (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport snk (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// ==== logic/simple_dual_port_ram.sv ====
//------------------------------------------------
// One write port, one read port, same clock
// Read data appears one cycle after the address
// Same-address read and write returns old data
//------------------------------------------------
`timescale 1ns/1ps

module simple_dual_port_ram #(
  parameter int data_width = 16,
  parameter int addr_width = 2,
  parameter int depth = 4
) (
  input  logic                  clk,
  input  logic [addr_width-1:0] wr_addr,
  input  logic [data_width-1:0] wr_din,
  input  logic                  wr_en,
  input  logic [addr_width-1:0] rd_addr,
  output logic [data_width-1:0] rd_dout
);

  logic [data_width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_din;
    end
    rd_dout <= mem[rd_addr];
  end

endmodule

// ==== logic/repeat_circular_buffer.sv ====
//------------------------------------------------
// Holds one vector of MXV_N elements and replays
// it MXV_M times in order
// A slot is freed only by its last replay
// Output latency varies, watch out_valid
//------------------------------------------------
`timescale 1ns/1ps
`include "mxv_macros.svh"

module repeat_circular_buffer
  import mxv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  elem_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output elem_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int depth = `MXV_N;
  localparam int reps = `MXV_M;
  localparam int addr_w = $clog2(depth);
  localparam int ptr_w = addr_w + 1;
  localparam int rep_w = $clog2(reps);
  localparam logic [ptr_w-1:0] ptr_full = ptr_w'(depth);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);
  localparam logic [rep_w-1:0] rep_last = rep_w'(reps - 1);

  logic [ptr_w-1:0] write_ptr;
  logic [ptr_w-1:0] read_ptr;
  logic [ptr_w-1:0] size;
  logic [rep_w-1:0] rep;
  logic             started;

  // RAM read issued last cycle, data on rd_dout now
  logic             ram_dout_valid;
  logic             ram_wr_en;
  logic [$bits(elem_t)-1:0] ram_rd_dout;

  logic             rd_go;
  logic             release_slot;
  logic             pause_reads;
  logic             pop;
  logic             load_out;
  logic             load_extra;

  // out_reg is the head, extra_reg the beat behind it
  elem_t            out_reg_data;
  logic             out_reg_valid;
  elem_t            extra_reg_data;
  logic             extra_reg_valid;

  // Blocked when full or when the next slot still waits for its last replay
  assign in_ready = started && (size != ptr_full) && (write_ptr != ptr_full) &&
                    !(rep == rep_last && write_ptr == read_ptr);
  assign ram_wr_en = in_valid && in_ready;

  assign pop = out_reg_valid && out_ready;
  assign pause_reads = out_reg_valid && !out_ready;

  // First pass must trail the writer
  assign rd_go = (size != '0) && !pause_reads && !(rep == '0 && read_ptr == write_ptr);
  assign release_slot = rd_go && (rep == rep_last);

  assign load_out = ram_dout_valid && (!out_reg_valid || (pop && !extra_reg_valid));
  assign load_extra = ram_dout_valid && out_reg_valid && (!pop || extra_reg_valid);

  assign out_data = out_reg_data;
  assign out_valid = out_reg_valid;

  simple_dual_port_ram #(
    .data_width($bits(elem_t)),
    .addr_width(addr_w),
    .depth     (depth)
  ) u_ram (
    .clk    (clk),
    .wr_addr(write_ptr[addr_w-1:0]),
    .wr_din (in_data),
    .wr_en  (ram_wr_en),
    .rd_addr(read_ptr[addr_w-1:0]),
    .rd_dout(ram_rd_dout)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      write_ptr       <= '0;
      read_ptr        <= '0;
      size            <= '0;
      rep             <= '0;
      started         <= 1'b0;
      ram_dout_valid  <= 1'b0;
      out_reg_valid   <= 1'b0;
      extra_reg_valid <= 1'b0;
    end else begin
      started <= 1'b1;

      // Writer rewinds once the last replay of its vector has begun
      if (ram_wr_en) begin
        write_ptr <= write_ptr + 1'b1;
      end else if (write_ptr == ptr_full && rep == rep_last) begin
        write_ptr <= '0;
      end

      if (rd_go) begin
        if (read_ptr == ptr_last) begin
          read_ptr <= '0;
          rep <= (rep == rep_last) ? '0 : rep + 1'b1;
        end else begin
          read_ptr <= read_ptr + 1'b1;
        end
      end

      case ({ram_wr_en, release_slot})
        2'b10:   size <= size + 1'b1;
        2'b01:   size <= size - 1'b1;
        default: size <= size;
      endcase

      ram_dout_valid <= rd_go;

      if (pop) begin
        out_reg_valid   <= extra_reg_valid || ram_dout_valid;
        extra_reg_valid <= extra_reg_valid && ram_dout_valid;
      end else if (ram_dout_valid) begin
        out_reg_valid   <= 1'b1;
        extra_reg_valid <= out_reg_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop && extra_reg_valid) begin
      out_reg_data <= extra_reg_data;
    end else if (load_out) begin
      out_reg_data <= ram_rd_dout;
    end
    if (load_extra) begin
      extra_reg_data <= ram_rd_dout;
    end
  end

  // During the last replay a write only reuses slots the reader already freed
  assert property (@(posedge clk) disable iff (rst)
    ram_wr_en && rep == rep_last |-> write_ptr < read_ptr);

  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== logic/skid_buffer.sv ====
//------------------------------------------------
// Two-entry buffer on the matrix stream
// in_ready is a register, low only when full
// One cycle from accept to out.valid
//------------------------------------------------
`timescale 1ns/1ps

module skid_buffer
  import mxv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  elem_t in_data,
  input  logic  in_last,
  input  logic  in_valid,
  output logic  in_ready,
  stream_if.src out
);

  elem_t main_data;
  logic  main_last;
  logic  main_valid;
  elem_t skid_data;
  logic  skid_last;
  logic  skid_valid;
  logic  ready_q;
  logic  accept;
  logic  pop;
  logic  main_free;
  logic  main_valid_next;
  logic  skid_valid_next;

  assign in_ready = ready_q;
  assign accept = in_valid && ready_q;
  assign pop = main_valid && out.ready;
  assign main_free = !main_valid || pop;

  assign out.data = main_data;
  assign out.last = main_last;
  assign out.valid = main_valid;

  always_comb begin
    main_valid_next = main_valid;
    skid_valid_next = skid_valid;
    if (main_free) begin
      // Skid entry moves up first, new beat goes behind it
      main_valid_next = skid_valid || accept;
      skid_valid_next = skid_valid && accept;
    end else if (accept) begin
      skid_valid_next = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      main_valid <= main_valid_next;
      skid_valid <= skid_valid_next;
      ready_q    <= !(main_valid_next && skid_valid_next);
    end
  end

  always_ff @(posedge clk) begin
    if (main_free && skid_valid) begin
      main_data <= skid_data;
      main_last <= skid_last;
    end else if (main_free && accept) begin
      main_data <= in_data;
      main_last <= in_last;
    end
    if (accept && !(main_free && !skid_valid)) begin
      skid_data <= in_data;
      skid_last <= in_last;
    end
  end

  // Registered ready must track the occupancy of both entries
  assert property (@(posedge clk) disable iff (rst) accept |-> !(main_valid && skid_valid));

endmodule

// ==== logic/dot_product_unit.sv ====
//------------------------------------------------
// Joins vector and matrix beats, sums products
// A row ends on a matrix beat with last set
// Result wraps at the accumulator width
// Partial rows keep going while a result waits
//------------------------------------------------
`timescale 1ns/1ps

module dot_product_unit
  import mxv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  elem_t vec_data,
  input  logic  vec_valid,
  output logic  vec_ready,
  stream_if.snk mat,
  output acc_t  y_data,
  output logic  y_valid,
  input  logic  y_ready
);

  localparam int prod_w = 2 * $bits(elem_t);

  logic signed [prod_w-1:0] product;
  acc_t acc;
  acc_t sum;
  logic can_take;
  logic fire;
  logic row_done;

  // A row end needs the result register free, or freed this cycle
  assign can_take = !mat.last || !y_valid || y_ready;

  // Join, each side waits for the other
  assign vec_ready = mat.valid && can_take;
  assign mat.ready = vec_valid && can_take;
  assign fire = vec_valid && mat.valid && can_take;
  assign row_done = fire && mat.last;

  assign product = vec_data * mat.data;
  assign sum = acc + acc_t'(product);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc     <= '0;
      y_valid <= 1'b0;
    end else begin
      if (row_done) begin
        acc     <= '0;
        y_valid <= 1'b1;
      end else begin
        if (fire) begin
          acc <= sum;
        end
        if (y_ready) begin
          y_valid <= 1'b0;
        end
      end
    end
  end

  // Final sum of the row, held until taken
  always_ff @(posedge clk) begin
    if (row_done) begin
      y_data <= sum;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    y_valid && !y_ready |=> y_valid && $stable(y_data));

endmodule

// ==== logic/mxv_top.sv ====
//------------------------------------------------
// Streaming y = A*x for fixed MXV_M x MXV_N
// A arrives row-major, a_last on each row end
// a_last framing is not checked here
// One result per row on the y port
//------------------------------------------------
`timescale 1ns/1ps

module mxv_top
  import mxv_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  elem_t x_data,
  input  logic  x_valid,
  output logic  x_ready,
  input  elem_t a_data,
  input  logic  a_last,
  input  logic  a_valid,
  output logic  a_ready,
  output acc_t  y_data,
  output logic  y_valid,
  input  logic  y_ready
);

  // Replayed vector elements
  elem_t vec_data;
  logic  vec_valid;
  logic  vec_ready;

  stream_if mat ();

  repeat_circular_buffer u_repeat (
    .clk      (clk),
    .rst      (rst),
    .in_data  (x_data),
    .in_valid (x_valid),
    .in_ready (x_ready),
    .out_data (vec_data),
    .out_valid(vec_valid),
    .out_ready(vec_ready)
  );

  skid_buffer u_skid (
    .clk     (clk),
    .rst     (rst),
    .in_data (a_data),
    .in_last (a_last),
    .in_valid(a_valid),
    .in_ready(a_ready),
    .out     (mat)
  );

  dot_product_unit u_dot (
    .clk      (clk),
    .rst      (rst),
    .vec_data (vec_data),
    .vec_valid(vec_valid),
    .vec_ready(vec_ready),
    .mat      (mat),
    .y_data   (y_data),
    .y_valid  (y_valid),
    .y_ready  (y_ready)
  );

endmodule

// ==== verif/clk_rst_gen.sv ====
//------------------------------------------------
// Testbench clock and reset source
// 20 ns clock period
// rst is high for the first 8 rising edges
//------------------------------------------------
`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk,
  output logic rst
);

  localparam time half_period = 10ns;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Released on an edge so the DUT sees a full 8 reset cycles
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== verif/mxv_tb.sv ====
//------------------------------------------------
// Table-driven testbench for mxv_top
// Pass 0 streams all cases with no gaps
// Pass 1 repeats them with random input gaps
// and random y_ready back-pressure
// Inputs change 1 ns after the rising edge
//------------------------------------------------
`timescale 1ns/1ps
`include "mxv_macros.svh"

module mxv_tb
  import mxv_pkg::*;
();

  localparam int n_cases = 6;
  localparam int n_passes = 2;
  localparam int timeout_cycles = 300;
  localparam elem_t elem_min = {1'b1, {(`MXV_ELEM_W-1){1'b0}}};
  localparam elem_t elem_max = {1'b0, {(`MXV_ELEM_W-1){1'b1}}};

  logic  clk;
  logic  rst;
  elem_t x_data;
  logic  x_valid;
  logic  x_ready;
  elem_t a_data;
  logic  a_last;
  logic  a_valid;
  logic  a_ready;
  acc_t  y_data;
  logic  y_valid;
  logic  y_ready;

  // Stimulus and expected rows, one entry per case
  elem_t x_tab [n_cases][`MXV_N];
  elem_t a_tab [n_cases][`MXV_M][`MXV_N];
  acc_t  y_exp [n_cases][`MXV_M];

  logic [31:0] lfsr;
  int          error_count;

  clk_rst_gen u_clk_rst (
    .clk(clk),
    .rst(rst)
  );

  mxv_top uut (
    .clk    (clk),
    .rst    (rst),
    .x_data (x_data),
    .x_valid(x_valid),
    .x_ready(x_ready),
    .a_data (a_data),
    .a_last (a_last),
    .a_valid(a_valid),
    .a_ready(a_ready),
    .y_data (y_data),
    .y_valid(y_valid),
    .y_ready(y_ready)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // y[m] = sum of A[m][n] * x[n], signed, wrapped to the accumulator width
  function automatic acc_t expected_row(input int c, input int m);
    acc_t s;
    logic signed [63:0] p;
    s = '0;
    for (int n = 0; n < `MXV_N; n++) begin
      p = x_tab[c][n] * a_tab[c][m][n];
      s = acc_t'(s + p);
    end
    return s;
  endfunction

  task automatic stop_with_error(input string what);
    error_count++;
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic fill_table();
    logic [31:0] r;
    for (int c = 0; c < n_cases; c++) begin
      for (int n = 0; n < `MXV_N; n++) begin
        random_bits(`MXV_ELEM_W, r);
        if (c == 0) begin
          x_tab[c][n] = elem_t'(n + 1);
        end else if (c == 1) begin
          x_tab[c][n] = (n % 2 == 0) ? elem_min : elem_max;
        end else begin
          x_tab[c][n] = elem_t'(r);
        end
        for (int m = 0; m < `MXV_M; m++) begin
          random_bits(`MXV_ELEM_W, r);
          if (c == 0) begin
            a_tab[c][m][n] = elem_t'(m * `MXV_N + n + 1);
          end else if (c == 1) begin
            // Rows of all min, all max, then alternating
            if (m == 0) begin
              a_tab[c][m][n] = elem_min;
            end else if (m == 1) begin
              a_tab[c][m][n] = elem_max;
            end else begin
              a_tab[c][m][n] = (n % 2 == 0) ? elem_max : elem_min;
            end
          end else begin
            a_tab[c][m][n] = elem_t'(r);
          end
        end
      end
    end
    for (int c = 0; c < n_cases; c++) begin
      for (int m = 0; m < `MXV_M; m++) begin
        y_exp[c][m] = expected_row(c, m);
      end
    end
  endtask

  task automatic watch_reset();
    int waits;
    waits = 0;
    @(posedge clk);
    #1;
    while (rst) begin
      check_flag("y_valid", y_valid, 1'b0);
      check_flag("x_ready", x_ready, 1'b0);
      check_flag("a_ready", a_ready, 1'b0);
      @(posedge clk);
      #1;
      waits++;
      if (waits > timeout_cycles) begin
        stop_with_error("Timeout: reset was never released");
      end
    end
    // First cycle after release
    check_flag("y_valid", y_valid, 1'b0);
    check_flag("x_ready", x_ready, 1'b0);
    check_flag("a_ready", a_ready, 1'b0);
  endtask

  // Optional idle cycles before a beat, only in the gap pass
  task automatic input_gap(input int pass, output logic idle);
    logic [31:0] r;
    idle = 1'b0;
    if (pass == 1) begin
      random_bits(2, r);
      idle = (r[1:0] == 2'b00);
    end
  endtask

  task automatic send_x();
    logic [31:0] r;
    logic idle;
    int waits;
    for (int p = 0; p < n_passes; p++) begin
      for (int c = 0; c < n_cases; c++) begin
        for (int n = 0; n < `MXV_N; n++) begin
          input_gap(p, idle);
          if (idle) begin
            x_valid = 1'b0;
            random_bits(2, r);
            repeat (r[1:0] + 1) begin
              @(posedge clk);
              #1;
            end
          end
          x_data = x_tab[c][n];
          x_valid = 1'b1;
          waits = 0;
          // x_ready comes from registers only, stable until the next edge
          while (!x_ready) begin
            @(posedge clk);
            #1;
            waits++;
            if (waits > timeout_cycles) begin
              stop_with_error("Timeout: x_ready stayed low");
            end
          end
          @(posedge clk);
          #1;
        end
      end
    end
    x_valid = 1'b0;
  endtask

  task automatic send_a();
    logic [31:0] r;
    logic idle;
    int waits;
    for (int p = 0; p < n_passes; p++) begin
      for (int c = 0; c < n_cases; c++) begin
        for (int m = 0; m < `MXV_M; m++) begin
          for (int n = 0; n < `MXV_N; n++) begin
            input_gap(p, idle);
            if (idle) begin
              a_valid = 1'b0;
              random_bits(2, r);
              repeat (r[1:0] + 1) begin
                @(posedge clk);
                #1;
              end
            end
            a_data = a_tab[c][m][n];
            a_last = (n == `MXV_N - 1);
            a_valid = 1'b1;
            waits = 0;
            while (!a_ready) begin
              @(posedge clk);
              #1;
              waits++;
              if (waits > timeout_cycles) begin
                stop_with_error("Timeout: a_ready stayed low");
              end
            end
            @(posedge clk);
            #1;
          end
        end
      end
    end
    a_valid = 1'b0;
    a_last = 1'b0;
  endtask

  task automatic collect_y();
    logic [31:0] r;
    acc_t held;
    logic stalled;
    logic taken;
    int waits;
    stalled = 1'b0;
    held = '0;
    for (int p = 0; p < n_passes; p++) begin
      for (int c = 0; c < n_cases; c++) begin
        for (int m = 0; m < `MXV_M; m++) begin
          taken = 1'b0;
          waits = 0;
          while (!taken) begin
            // A stalled result must stay put
            if (stalled) begin
              check_flag("y_valid", y_valid, 1'b1);
              check_acc("y_data", y_data, held);
            end
            y_ready = 1'b1;
            if (p == 1) begin
              random_bits(2, r);
              y_ready = (r[1:0] != 2'b00);
            end
            if (y_valid && y_ready) begin
              check_acc("y_data", y_data, y_exp[c][m]);
              taken = 1'b1;
            end
            stalled = y_valid && !y_ready;
            held = y_data;
            @(posedge clk);
            #1;
            waits++;
            if (!taken && waits > timeout_cycles) begin
              stop_with_error("Timeout: no result arrived on y_valid");
            end
          end
        end
      end
    end
    y_ready = 1'b1;
  endtask

  // No extra results once every row has been taken
  task automatic watch_idle();
    y_ready = 1'b1;
    repeat (2 * `MXV_N * `MXV_M) begin
      check_flag("y_valid", y_valid, 1'b0);
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    x_data = '0;
    x_valid = 1'b0;
    a_data = '0;
    a_last = 1'b0;
    a_valid = 1'b0;
    y_ready = 1'b0;
    lfsr = 32'h9ef6_5cf6;
    error_count = 0;
    fill_table();
    watch_reset();
    fork
      send_x();
      send_a();
      collect_y();
    join
    watch_idle();
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+logic
logic/mxv_pkg.sv
logic/stream_if.sv
logic/simple_dual_port_ram.sv
logic/repeat_circular_buffer.sv
logic/skid_buffer.sv
logic/dot_product_unit.sv
logic/mxv_top.sv
verif/clk_rst_gen.sv
verif/mxv_tb.sv

// ==== Bender.yml ====
package:
  name: mxv

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mxv_pkg.sv
      - logic/stream_if.sv
      - logic/simple_dual_port_ram.sv
      - logic/repeat_circular_buffer.sv
      - logic/skid_buffer.sv
      - logic/dot_product_unit.sv
      - logic/mxv_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/clk_rst_gen.sv
      - verif/mxv_tb.sv
